// ==== include/wb_consts.svh ====
/* sizing for the writeback subsystem
   RNBIT must equal log2(RNDEPTH), and PHY_REGS follows from the other two */
`ifndef WB_CONSTS_SVH
`define WB_CONSTS_SVH

// integer register width
`define XLEN 64

// architectural registers, x0 included
`define ARCH_REGS 32

// physical copies kept per architectural register
`define RNDEPTH 4

// bits to pick one copy
`define RNBIT 2

// copy index is regnum*RNDEPTH+depth
`define PHY_REGS (`ARCH_REGS * `RNDEPTH)

`endif

// ==== rtl/wb_pkg.sv ====
/* data, register index and opcode types for the writeback subsystem
   OP_LOAD goes to the load port and is never executed by the ALU */
`include "wb_consts.svh"

package wb_pkg;

	// one register word
	typedef logic [`XLEN-1:0] xlen_t;

	// architectural register number
	typedef logic [4:0] arch_idx_t;

	// physical address with the arch number on top and the copy number in the low RNBIT bits
	typedef logic [5+`RNBIT-1:0] phy_idx_t;

	typedef enum logic [3:0] {
		OP_ADD  = 4'd0,
		OP_SUB  = 4'd1,
		OP_AND  = 4'd2,
		OP_OR   = 4'd3,
		OP_XOR  = 4'd4,
		OP_SLL  = 4'd5,
		OP_SRL  = 4'd6,
		OP_SRA  = 4'd7,
		OP_SLT  = 4'd8,
		OP_SLTU = 4'd9,
		OP_LOAD = 4'd10
	} alu_op_e;

endpackage

// ==== rtl/rename_table.sv ====
/* rename and commit pointers per register; at most RNDEPTH-1 copies in flight
   copy 0 of every register is the committed one after reset */
`timescale 1ns/1ps
`include "wb_consts.svh"

module rename_table import wb_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 alloc_valid,
	input  arch_idx_t            alloc_rd,
	input  arch_idx_t            rs1,
	input  arch_idx_t            rs2,
	input  logic                 commit_valid,
	input  arch_idx_t            commit_rd,
	input  logic [`PHY_REGS-1:0] written,
	input  arch_idx_t            arch_rd,
	output phy_idx_t             rs1_phy,
	output phy_idx_t             rs2_phy,
	output phy_idx_t             rd_phy,
	output logic                 rd_free,
	output logic                 commit_ready,
	output logic [`PHY_REGS-1:0] log_clear,
	output phy_idx_t             commit_phy
);

	logic [`RNBIT-1:0] rename_ptr [`ARCH_REGS];
	logic [`RNBIT-1:0] commit_ptr [`ARCH_REGS];
	logic [`RNBIT-1:0] inflight [`ARCH_REGS];

	phy_idx_t oldest_phy;
	logic     commit_fire;

	// sources read the newest copy
	assign rs1_phy = {rs1, rename_ptr[rs1]};
	assign rs2_phy = {rs2, rename_ptr[rs2]};

	// rd takes the next copy after the rename pointer around the ring
	assign rd_phy  = {alloc_rd, rename_ptr[alloc_rd] + `RNBIT'd1};
	assign rd_free = (inflight[alloc_rd] < (`RNDEPTH - 1));

	// oldest uncommitted copy must be written before it can retire
	assign oldest_phy   = {commit_rd, commit_ptr[commit_rd] + `RNBIT'd1};
	assign commit_ready = (inflight[commit_rd] != '0) && written[oldest_phy];
	assign commit_fire  = commit_valid && commit_ready;

	assign commit_phy = {arch_rd, commit_ptr[arch_rd]};

	// the copy replaced at commit goes back to the free ring
	always_comb begin
		log_clear = '0;
		if (commit_fire) begin
			log_clear[{commit_rd, commit_ptr[commit_rd]}] = 1'b1;
		end
	end

	for (genvar r = 0; r < `ARCH_REGS; r++) begin : g_reg
		logic alloc_hit;
		logic commit_hit;

		assign alloc_hit  = alloc_valid && (alloc_rd == arch_idx_t'(r));
		assign commit_hit = commit_fire && (commit_rd == arch_idx_t'(r));

		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				rename_ptr[r] <= '0;
				commit_ptr[r] <= '0;
				inflight[r]   <= '0;
			end else begin
				if (alloc_hit) begin
					rename_ptr[r] <= rename_ptr[r] + `RNBIT'd1;
				end
				if (commit_hit) begin
					commit_ptr[r] <= commit_ptr[r] + `RNBIT'd1;
				end
				// alloc and commit together leave the count alone
				case ({alloc_hit, commit_hit})
					2'b10:   inflight[r] <= inflight[r] + `RNBIT'd1;
					2'b01:   inflight[r] <= inflight[r] - `RNBIT'd1;
					default: inflight[r] <= inflight[r];
				endcase
			end
		end
	end

endmodule

// ==== rtl/int_alu.sv ====
/* single stage RV64 integer ALU, full 64-bit ops only (no W forms)
   one op in flight, result valid the cycle after op_valid */
`timescale 1ns/1ps
`include "wb_consts.svh"

module int_alu import wb_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      op_valid,
	input  alu_op_e   op,
	input  phy_idx_t  op_rd,
	input  xlen_t     src_a,
	input  xlen_t     src_b,
	output logic      wb_valid,
	output phy_idx_t  wb_rd,
	output xlen_t     wb_res
);

	logic [5:0] shamt;
	xlen_t      res;

	// RV64 shifts take the low 6 bits of b
	assign shamt = src_b[5:0];

	always_comb begin
		case (op)
			OP_ADD:  res = src_a + src_b;
			OP_SUB:  res = src_a - src_b;
			OP_AND:  res = src_a & src_b;
			OP_OR:   res = src_a | src_b;
			OP_XOR:  res = src_a ^ src_b;
			OP_SLL:  res = src_a << shamt;
			OP_SRL:  res = src_a >> shamt;
			OP_SRA:  res = $signed(src_a) >>> shamt;
			OP_SLT: begin
				res = {{(`XLEN-1){1'b0}}, ($signed(src_a) < $signed(src_b))};
			end
			OP_SLTU: begin
				res = {{(`XLEN-1){1'b0}}, (src_a < src_b)};
			end
			// loads never arrive here
			default: res = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= op_valid;
		end
	end

	// result and tag only move with a valid op
	always_ff @(posedge clk) begin
		if (op_valid) begin
			wb_rd  <= op_rd;
			wb_res <= res;
		end
	end

endmodule

// ==== rtl/writeback.sv ====
/* merges ALU and load results into the next register file state
   both ports may fire in one cycle as long as they target different copies */
`timescale 1ns/1ps
`include "wb_consts.svh"

module writeback import wb_pkg::*; (
	input  logic                         alu_wb_valid,
	input  phy_idx_t                     alu_wb_rd,
	input  xlen_t                        alu_wb_res,
	input  logic                         lsu_wb_valid,
	input  phy_idx_t                     lsu_wb_rd,
	input  xlen_t                        lsu_wb_res,
	input  logic [`PHY_REGS*`XLEN-1:0]   regfile_qout,
	output logic [`PHY_REGS*`XLEN-1:0]   regfile_dnxt,
	output logic [`PHY_REGS-1:0]         log_set
);

	// x0 copies hold zero and are never marked by writeback
	assign regfile_dnxt[0 +: `RNDEPTH*`XLEN] = '0;
	assign log_set[`RNDEPTH-1:0] = '0;

	for (genvar reg_num = 1; reg_num < `ARCH_REGS; reg_num++) begin : g_reg
		for (genvar depth = 0; depth < `RNDEPTH; depth++) begin : g_copy
			localparam int SEL = reg_num*`RNDEPTH + depth;

			logic alu_hit;
			logic lsu_hit;

			assign alu_hit = alu_wb_valid && (alu_wb_rd == phy_idx_t'(SEL));
			assign lsu_hit = lsu_wb_valid && (lsu_wb_rd == phy_idx_t'(SEL));

			// a copy has one producer, so the order here never matters
			assign regfile_dnxt[`XLEN*SEL +: `XLEN] = alu_hit ? alu_wb_res :
				lsu_hit ? lsu_wb_res : regfile_qout[`XLEN*SEL +: `XLEN];

			assign log_set[SEL] = alu_hit | lsu_hit;
		end
	end

endmodule

// ==== rtl/phy_regfile.sv ====
/* physical register storage with per-copy written bits
   reset zeroes every copy and marks copy 0 of each register written */
`timescale 1ns/1ps
`include "wb_consts.svh"

module phy_regfile import wb_pkg::*; (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic [`PHY_REGS*`XLEN-1:0]   regfile_dnxt,
	input  logic [`PHY_REGS-1:0]         log_set,
	input  logic [`PHY_REGS-1:0]         log_clear,
	output logic [`PHY_REGS*`XLEN-1:0]   regfile_qout,
	output logic [`PHY_REGS-1:0]         written,
	input  phy_idx_t                     rd_a_idx,
	input  phy_idx_t                     rd_b_idx,
	output xlen_t                        rd_a_data,
	output xlen_t                        rd_b_data,
	input  phy_idx_t                     arch_phy_idx,
	output xlen_t                        arch_data
);

	// lowest copy of each register group starts out written
	localparam logic [`PHY_REGS-1:0] LOG_RST = {`ARCH_REGS{{(`RNDEPTH-1){1'b0}}, 1'b1}};

	logic [`PHY_REGS*`XLEN-1:0] regfile_q;
	logic [`PHY_REGS-1:0]       log_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			regfile_q <= '0;
		end else begin
			regfile_q <= regfile_dnxt;
		end
	end

	// a freed copy is never written in the same cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			log_q <= LOG_RST;
		end else begin
			log_q <= (log_q & ~log_clear) | log_set;
		end
	end

	assign regfile_qout = regfile_q;
	assign written      = log_q;

	// operand ports
	assign rd_a_data = regfile_q[rd_a_idx*`XLEN +: `XLEN];
	assign rd_b_data = regfile_q[rd_b_idx*`XLEN +: `XLEN];

	// committed copy for the architectural read
	assign arch_data = regfile_q[arch_phy_idx*`XLEN +: `XLEN];

endmodule

// ==== rtl/wb_core_top.sv ====
/* in-order dispatch into one ALU and an external load port, no flush or exceptions
   dispatch stalls until both sources are written; x0 writes are dropped */
`timescale 1ns/1ps
`include "wb_consts.svh"

module wb_core_top import wb_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      disp_valid,
	output logic      disp_ready,
	input  alu_op_e   disp_op,
	input  arch_idx_t disp_rs1,
	input  arch_idx_t disp_rs2,
	input  arch_idx_t disp_rd,
	input  xlen_t     disp_imm,
	input  logic      disp_use_imm,
	output logic      ld_req_valid,
	input  logic      ld_req_ready,
	output xlen_t     ld_req_addr,
	output phy_idx_t  ld_req_tag,
	input  logic      ld_rsp_valid,
	input  phy_idx_t  ld_rsp_tag,
	input  xlen_t     ld_rsp_data,
	input  logic      commit_valid,
	input  arch_idx_t commit_rd,
	output logic      commit_ready,
	input  arch_idx_t arch_rd_addr,
	output xlen_t     arch_rd_data
);

	phy_idx_t rs1_phy, rs2_phy, rd_phy, commit_phy, dest_phy;
	logic     rd_free;
	logic     is_load, rd_nz, src_ok, rd_ok, disp_fire;
	xlen_t    rs1_data, rs2_data, op_b, arch_data;

	logic [`PHY_REGS-1:0]       written, log_set, log_clear;
	logic [`PHY_REGS*`XLEN-1:0] regfile_qout, regfile_dnxt;

	logic     alu_wb_valid;
	phy_idx_t alu_wb_rd;
	xlen_t    alu_wb_res;

	assign is_load = (disp_op == OP_LOAD);
	assign rd_nz   = (disp_rd != '0);

	// stall rule
	assign src_ok = written[rs1_phy] & written[rs2_phy];
	assign rd_ok  = ~rd_nz | rd_free;

	assign disp_ready = src_ok & rd_ok & (~is_load | ld_req_ready);
	assign disp_fire  = disp_valid & disp_ready;

	// x0 results land on copy 0 of x0, which writeback ignores
	assign dest_phy = rd_nz ? rd_phy : '0;
	assign op_b     = disp_use_imm ? disp_imm : rs2_data;

	// request leaves in the same cycle as the dispatch transfer
	assign ld_req_valid = disp_valid & is_load & src_ok & rd_ok;
	assign ld_req_addr  = rs1_data + disp_imm;
	assign ld_req_tag   = dest_phy;

	assign arch_rd_data = (arch_rd_addr == '0) ? '0 : arch_data;

	rename_table rename_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.alloc_valid  (disp_fire & rd_nz),
		.alloc_rd     (disp_rd),
		.rs1          (disp_rs1),
		.rs2          (disp_rs2),
		.commit_valid (commit_valid),
		.commit_rd    (commit_rd),
		.written      (written),
		.arch_rd      (arch_rd_addr),
		.rs1_phy      (rs1_phy),
		.rs2_phy      (rs2_phy),
		.rd_phy       (rd_phy),
		.rd_free      (rd_free),
		.commit_ready (commit_ready),
		.log_clear    (log_clear),
		.commit_phy   (commit_phy)
	);

	int_alu alu_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.op_valid (disp_fire & ~is_load & rd_nz),
		.op       (disp_op),
		.op_rd    (dest_phy),
		.src_a    (rs1_data),
		.src_b    (op_b),
		.wb_valid (alu_wb_valid),
		.wb_rd    (alu_wb_rd),
		.wb_res   (alu_wb_res)
	);

	writeback wb_i (
		.alu_wb_valid (alu_wb_valid),
		.alu_wb_rd    (alu_wb_rd),
		.alu_wb_res   (alu_wb_res),
		.lsu_wb_valid (ld_rsp_valid),
		.lsu_wb_rd    (ld_rsp_tag),
		.lsu_wb_res   (ld_rsp_data),
		.regfile_qout (regfile_qout),
		.regfile_dnxt (regfile_dnxt),
		.log_set      (log_set)
	);

	phy_regfile regfile_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.regfile_dnxt (regfile_dnxt),
		.log_set      (log_set),
		.log_clear    (log_clear),
		.regfile_qout (regfile_qout),
		.written      (written),
		.rd_a_idx     (rs1_phy),
		.rd_b_idx     (rs2_phy),
		.rd_a_data    (rs1_data),
		.rd_b_data    (rs2_data),
		.arch_phy_idx (commit_phy),
		.arch_data    (arch_data)
	);

endmodule

// ==== test/wb_clk_gen.sv ====
/* 20 ns clock, rst_n held low for the first 5 rising edges */
`timescale 1ns/1ps

module wb_clk_gen (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// release just after the fifth edge
	initial begin
		rst_n = 1'b0;
		repeat (5) @(posedge clk);
		#1 rst_n = 1'b1;
	end

endmodule

// ==== test/wb_tb.sv ====
/* directed tests for wb_core_top; ld_req_ready is held high throughout
   load words come from a 256-word model indexed by address bits 10:3 */
`timescale 1ns/1ps
`include "wb_consts.svh"

module wb_tb import wb_pkg::*; ();

	logic      clk, rst_n;
	logic      disp_valid, disp_ready, disp_use_imm;
	alu_op_e   disp_op;
	arch_idx_t disp_rs1, disp_rs2, disp_rd, commit_rd, arch_rd_addr;
	xlen_t     disp_imm, ld_req_addr, ld_rsp_data, arch_rd_data;
	logic      ld_req_valid, ld_req_ready, ld_rsp_valid, commit_valid, commit_ready;
	phy_idx_t  ld_req_tag, ld_rsp_tag;

	integer seed;
	int     errors, checks, err_mark;
	xlen_t  mem [256];

	// newest value and committed value of each register
	xlen_t ref_spec [`ARCH_REGS];
	xlen_t ref_arch [`ARCH_REGS];
	// values waiting for commit in one ring per register
	xlen_t pend_val [`ARCH_REGS][`RNDEPTH];
	int    pend_head [`ARCH_REGS];
	int    pend_cnt [`ARCH_REGS];

	// outstanding load responses
	phy_idx_t rsp_tag_q [$];
	xlen_t    rsp_data_q [$];
	int       rsp_wait_q [$];

	wb_clk_gen clk_gen_i (.clk(clk), .rst_n(rst_n));

	wb_core_top dut_i (.*);

	function automatic xlen_t rand_word();
		return {$random(seed), $random(seed)};
	endfunction

	// one of x1..x10
	function automatic arch_idx_t rand_reg();
		return arch_idx_t'(1 + {$random(seed)} % 10);
	endfunction

	function automatic xlen_t alu_ref(input alu_op_e op, input xlen_t a, input xlen_t b);
		int    sh;
		xlen_t sign_bit;
		sh = int'(b[5:0]);
		sign_bit = {1'b1, 63'd0};
		case (op)
			OP_ADD:  return a + b;
			OP_SUB:  return a - b;
			OP_AND:  return a & b;
			OP_OR:   return a | b;
			OP_XOR:  return a ^ b;
			OP_SLL:  return a << sh;
			OP_SRL:  return a >> sh;
			// fill the vacated top bits with the sign
			OP_SRA:  return (a >> sh) | (a[63] ? ~({64{1'b1}} >> sh) : 64'd0);
			// flipping the sign bits turns a signed compare into an unsigned one
			OP_SLT:  return xlen_t'((a ^ sign_bit) < (b ^ sign_bit));
			OP_SLTU: return xlen_t'(a < b);
			default: return '0;
		endcase
	endfunction

	task automatic check(input string name, input xlen_t exp, input xlen_t act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("Fail %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic abort_run(input string what);
		$display("timeout while waiting for %s", what);
		$display("sim failed");
		$finish;
	endtask

	task automatic finish_test(input string name);
		$display("test %s finished with %0d errors", name, errors - err_mark);
		err_mark = errors;
	endtask

	// starts and ends 1 ns after a rising edge
	task automatic issue(input alu_op_e op, input arch_idx_t rd, input arch_idx_t rs1,
			input arch_idx_t rs2, input xlen_t imm, input logic use_imm);
		xlen_t addr;
		xlen_t v;
		int    t;
		addr = ref_spec[rs1] + imm;
		if (op == OP_LOAD)
			v = mem[addr[10:3]];
		else
			v = alu_ref(op, ref_spec[rs1], use_imm ? imm : ref_spec[rs2]);
		disp_valid = 1'b1;
		disp_op = op;
		disp_rd = rd;
		disp_rs1 = rs1;
		disp_rs2 = rs2;
		disp_imm = imm;
		disp_use_imm = use_imm;
		t = 0;
		@(negedge clk);
		while (!disp_ready && t < 200) begin
			@(negedge clk);
			t++;
		end
		if (!disp_ready) begin
			abort_run("disp_ready");
		end else begin
			// a load request goes out with the dispatch transfer
			check("load request", xlen_t'(op == OP_LOAD), xlen_t'(ld_req_valid));
			if (op == OP_LOAD)
				check("load request", addr, ld_req_addr);
			@(posedge clk);
			#1;
			disp_valid = 1'b0;
			if (rd != '0) begin
				ref_spec[rd] = v;
				pend_val[rd][(pend_head[rd] + pend_cnt[rd]) % `RNDEPTH] = v;
				pend_cnt[rd]++;
			end
		end
	endtask

	task automatic retire(input arch_idx_t rd);
		int t;
		commit_valid = 1'b1;
		commit_rd = rd;
		t = 0;
		@(negedge clk);
		while (!commit_ready && t < 200) begin
			@(negedge clk);
			t++;
		end
		if (!commit_ready) begin
			abort_run("commit_ready");
		end else begin
			@(posedge clk);
			#1;
			commit_valid = 1'b0;
			ref_arch[rd] = pend_val[rd][pend_head[rd]];
			pend_head[rd] = (pend_head[rd] + 1) % `RNDEPTH;
			pend_cnt[rd]--;
		end
	endtask

	task automatic check_arch(input string name, input arch_idx_t r);
		arch_rd_addr = r;
		@(negedge clk);
		check(name, ref_arch[r], arch_rd_data);
		@(posedge clk);
		#1;
	endtask

	// retire everything in flight, then read back all registers
	task automatic commit_all(input string name);
		for (int r = 1; r < `ARCH_REGS; r++) begin
			while (pend_cnt[r] > 0)
				retire(arch_idx_t'(r));
		end
		for (int r = 0; r < `ARCH_REGS; r++)
			check_arch(name, arch_idx_t'(r));
	endtask

	task automatic test_reset();
		for (int r = 0; r < `ARCH_REGS; r++)
			check_arch("reset", arch_idx_t'(r));
		check("reset", 64'd1, xlen_t'(disp_ready));
		check("reset", 64'd0, xlen_t'(ld_req_valid));
		finish_test("reset");
	endtask

	task automatic test_alu();
		alu_op_e ops [10];
		ops = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU};
		for (int r = 1; r <= 10; r++)
			issue(OP_ADD, arch_idx_t'(r), 0, 0, rand_word(), 1'b1);
		// every third op takes the immediate
		for (int i = 0; i < 10; i++)
			issue(ops[i], arch_idx_t'(11 + i), rand_reg(), rand_reg(), rand_word(), i % 3 == 0);
		commit_all("alu");
		finish_test("alu");
	endtask

	task automatic test_chain();
		issue(OP_ADD, 21, 1, 2, '0, 1'b0);
		issue(OP_XOR, 22, 21, 3, '0, 1'b0);
		issue(OP_SUB, 23, 22, 21, '0, 1'b0);
		issue(OP_SRA, 24, 23, 0, rand_word(), 1'b1);
		issue(OP_SLT, 25, 24, 22, '0, 1'b0);
		issue(OP_SLL, 21, 25, 23, '0, 1'b0);
		commit_all("chain");
		finish_test("chain");
	endtask

	task automatic test_exhaust();
		for (int i = 0; i < `RNDEPTH - 1; i++)
			issue(OP_ADD, 26, 0, 0, rand_word(), 1'b1);
		// one more write to x26 has no copy left
		disp_valid = 1'b1;
		disp_op = OP_ADD;
		disp_rd = 26;
		disp_rs1 = 0;
		disp_rs2 = 0;
		disp_imm = 64'h1234;
		disp_use_imm = 1'b1;
		repeat (3) begin
			@(negedge clk);
			check("exhaust", 64'd0, xlen_t'(disp_ready));
		end
		@(posedge clk);
		#1;
		disp_valid = 1'b0;
		retire(26);
		check_arch("exhaust", 26);
		issue(OP_ADD, 26, 0, 0, 64'h1234, 1'b1);
		commit_all("exhaust");
		finish_test("exhaust");
	endtask

	task automatic test_loads();
		for (int i = 0; i < 6; i++) begin
			issue(OP_LOAD, arch_idx_t'(1 + i), (i == 3) ? 20 : 0, 0,
				xlen_t'({$random(seed)} % 256 * 8), 1'b1);
			// the load just sent cannot have answered yet
			commit_rd = arch_idx_t'(1 + i);
			@(negedge clk);
			check("loads", 64'd0, xlen_t'(commit_ready));
			@(posedge clk);
			#1;
			issue(OP_OR, arch_idx_t'(11 + i), rand_reg(), 0, rand_word(), 1'b1);
		end
		commit_all("loads");
		finish_test("loads");
	endtask

	task automatic test_x0();
		issue(OP_ADD, 0, 1, 2, '0, 1'b0);
		issue(OP_LOAD, 0, 0, 0, 64'h40, 1'b1);
		issue(OP_SUB, 0, 3, 0, rand_word(), 1'b1);
		// x0 sources still read zero after the dropped writes
		issue(OP_ADD, 27, 0, 0, rand_word(), 1'b1);
		issue(OP_SUB, 28, 3, 0, '0, 1'b0);
		commit_all("x0");
		finish_test("x0");
	endtask

	// load memory model takes requests where the inputs are settled
	always @(negedge clk) begin
		if (ld_req_valid && ld_req_ready) begin
			rsp_tag_q.push_back(ld_req_tag);
			rsp_data_q.push_back(mem[ld_req_addr[10:3]]);
			rsp_wait_q.push_back(1 + {$random(seed)} % 8);
		end
	end

	// newest expired entry goes first, so responses come back out of order
	always @(posedge clk) begin
		int pick;
		#1;
		pick = -1;
		foreach (rsp_wait_q[i]) begin
			if (rsp_wait_q[i] > 0)
				rsp_wait_q[i]--;
			if (rsp_wait_q[i] == 0)
				pick = i;
		end
		if (pick >= 0) begin
			ld_rsp_valid = 1'b1;
			ld_rsp_tag = rsp_tag_q[pick];
			ld_rsp_data = rsp_data_q[pick];
			rsp_tag_q.delete(pick);
			rsp_data_q.delete(pick);
			rsp_wait_q.delete(pick);
		end else begin
			ld_rsp_valid = 1'b0;
		end
	end

	initial begin
		int t;
		seed = 32'hfaad_4ef0;
		errors = 0;
		checks = 0;
		err_mark = 0;
		disp_valid = 1'b0;
		disp_op = OP_ADD;
		disp_rs1 = '0;
		disp_rs2 = '0;
		disp_rd = '0;
		disp_imm = '0;
		disp_use_imm = 1'b0;
		ld_req_ready = 1'b1;
		ld_rsp_valid = 1'b0;
		ld_rsp_tag = '0;
		ld_rsp_data = '0;
		commit_valid = 1'b0;
		commit_rd = '0;
		arch_rd_addr = '0;
		for (int i = 0; i < 256; i++)
			mem[i] = rand_word() ^ xlen_t'(i);
		for (int r = 0; r < `ARCH_REGS; r++) begin
			ref_spec[r] = '0;
			ref_arch[r] = '0;
			pend_head[r] = 0;
			pend_cnt[r] = 0;
		end
		t = 0;
		while (rst_n !== 1'b1 && t < 20) begin
			@(posedge clk);
			t++;
		end
		if (rst_n !== 1'b1) begin
			abort_run("reset release");
		end else begin
			@(posedge clk);
			#1;
			test_reset();
			test_alu();
			test_chain();
			test_exhaust();
			test_loads();
			test_x0();
			$display("checks %0d, errors %0d", checks, errors);
			if (errors == 0)
				$display("sim passed");
			else
				$display("sim failed");
			$finish;
		end
	end

endmodule

// ==== list.f ====
+incdir+include
rtl/wb_pkg.sv
rtl/rename_table.sv
rtl/int_alu.sv
rtl/writeback.sv
rtl/phy_regfile.sv
rtl/wb_core_top.sv
test/wb_clk_gen.sv
test/wb_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
	-f list.f --top-module wb_tb -o wb_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/wb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "sim passed" "$LOG"; then
	exit 0
fi
exit 1
